/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_load_store_buffer
FILELIST = vlog.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
PASS_MSG = all tests passed
SOURCES  = $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/lsb_properties.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module lsb_properties (
  input logic                  clk,
  input logic                  rst,
  input logic [`ROB_TAG_W-1:0] issue_dest,
  input logic                  full,
  input logic [`ROB_TAG_W-1:0] commit_dest,
  input logic                  mem_valid,
  input logic                  mem_ready,
  input logic                  mem_we,
  input logic [`XLEN-1:0]      mem_addr,
  input logic [`XLEN-1:0]      mem_wdata,
  input logic [`STRB_W-1:0]    mem_strb
);

  int commits;
  int writes;

  always_ff @(posedge clk) begin
    if (rst) begin
      commits <= 0;
      writes  <= 0;
    end else begin
      if (commit_dest != '0) begin
        commits <= commits + 1;
      end
      if (mem_valid && mem_we && mem_ready) begin
        writes <= writes + 1;
      end
    end
  end

  // request held with fixed fields until the memory answers
  assert property (@(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_we) && $stable(mem_addr) &&
      $stable(mem_wdata) && $stable(mem_strb))
    else $error("memory request changed before mem_ready");

  assert property (@(posedge clk) disable iff (rst) full |-> issue_dest == '0)
    else $error("allocation while the queue is full");

  // every write needs a commit seen earlier
  assert property (@(posedge clk) disable iff (rst) mem_valid && mem_we |-> commits > writes)
    else $error("store written to memory without a commit");

endmodule

bind load_store_buffer lsb_properties u_props (.*);

/* tb/lsb_tb_memory.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module lsb_tb_memory (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall,
  input  logic               mem_valid,
  input  logic               mem_we,
  input  logic [`XLEN-1:0]   mem_addr,
  input  logic [`XLEN-1:0]   mem_wdata,
  input  logic [`STRB_W-1:0] mem_strb,
  output logic               mem_ready,
  output logic [`XLEN-1:0]   mem_rdata
);

  logic [`XLEN-1:0] image [256];
  integer           seed = 32'hb2d2be03;
  logic             active;
  int               delay;
  logic [7:0]       idx;

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    active    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      image[i] = {i[7:0] ^ 8'h3c, ~i[7:0], i[7:0] + 8'h81, i[7:0]};
    end
  end

  // answer on the falling edge, 1 to 4 cycles after the request
  always @(negedge clk) begin
    mem_ready = 1'b0;
    if (rst) begin
      active = 1'b0;
    end else if (mem_valid && !active) begin
      active = 1'b1;
      delay  = 1 + {$random(seed)} % 4;
    end
    if (active && !stall) begin
      delay = delay - 1;
      if (delay == 0) begin
        idx = mem_addr[9:2];
        for (int b = 0; b < `STRB_W; b++) begin
          if (mem_we && mem_strb[b]) begin
            image[idx][8*b +: 8] = mem_wdata[8*b +: 8];
          end
        end
        mem_rdata = image[idx];
        mem_ready = 1'b1;
        active    = 1'b0;
      end
    end
  end

endmodule

/* tb/tb_load_store_buffer.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module tb_load_store_buffer;

  logic                  clk;
  logic                  rst;
  logic [`ROB_TAG_W-1:0] issue_dest;
  lsb_pkg::ls_op_e       issue_op;
  logic [`ROB_TAG_W-1:0] issue_qj;
  logic [`XLEN-1:0]      issue_vj;
  logic [`ROB_TAG_W-1:0] issue_qk;
  logic [`XLEN-1:0]      issue_vk;
  logic [`IMM_W-1:0]     issue_imm;
  logic [`ROB_TAG_W-1:0] alu_dest;
  logic [`XLEN-1:0]      alu_value;
  logic [`ROB_TAG_W-1:0] commit_dest;
  logic                  mem_ready;
  logic [`XLEN-1:0]      mem_rdata;
  logic                  full;
  logic                  mem_valid;
  logic                  mem_we;
  logic [`XLEN-1:0]      mem_addr;
  logic [`XLEN-1:0]      mem_wdata;
  logic [`STRB_W-1:0]    mem_strb;
  logic [`ROB_TAG_W-1:0] ld_dest;
  logic [`XLEN-1:0]      ld_value;
  logic                  stall;
  logic [`ROB_TAG_W-1:0] tag;
  logic [`ROB_TAG_W-1:0] exp_tag_q [$];
  logic [`XLEN-1:0]      exp_val_q [$];
  string                 exp_name_q [$];
  string                 test_name;
  integer                seed = 32'hb2d2be03;

  load_store_buffer uut (.*);
  lsb_tb_memory mem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // lane pick with sign or zero extension
  function automatic logic [`XLEN-1:0] expect_load(lsb_pkg::ls_op_e op, logic [`XLEN-1:0] addr,
                                                   logic [`XLEN-1:0] image [256]);
    logic [`XLEN-1:0] w;
    logic [7:0]       b;
    logic [15:0]      h;
    w = image[addr[9:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    case (op)
      lsb_pkg::op_lb:  return {{24{b[7]}}, b};
      lsb_pkg::op_lbu: return {24'b0, b};
      lsb_pkg::op_lh:  return {{16{h[15]}}, h};
      lsb_pkg::op_lhu: return {16'b0, h};
      default:         return w;
    endcase
  endfunction

  task automatic stop_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic take_tag();
    tag = (tag == 4'd15) ? 4'd1 : tag + 4'd1;
  endtask

  task automatic expect_result(logic [`ROB_TAG_W-1:0] t, logic [`XLEN-1:0] v);
    exp_tag_q.push_back(t);
    exp_val_q.push_back(v);
    exp_name_q.push_back(test_name);
  endtask

  task automatic alloc_op(logic [`ROB_TAG_W-1:0] dest, lsb_pkg::ls_op_e op,
                          logic [`ROB_TAG_W-1:0] qj, logic [`XLEN-1:0] vj,
                          logic [`XLEN-1:0] vk, logic [`IMM_W-1:0] imm);
    int t;
    t = 0;
    while (full) begin
      @(negedge clk);
      t++;
      if (t > 100) stop_run("timed out waiting for the queue to leave full");
    end
    issue_dest = dest;
    issue_op   = op;
    issue_qj   = qj;
    issue_vj   = vj;
    issue_vk   = vk;
    issue_imm  = imm;
    @(negedge clk);
    issue_dest = '0;
  endtask

  // load with a known base
  task automatic load_known(lsb_pkg::ls_op_e op, logic [`XLEN-1:0] vj, logic [`IMM_W-1:0] imm);
    take_tag();
    expect_result(tag, expect_load(op, vj + {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm}, mem.image));
    alloc_op(tag, op, '0, vj, '0, imm);
  endtask

  task automatic wait_done(int limit);
    int t;
    t = 0;
    while (exp_tag_q.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > limit) stop_run($sformatf("timed out in %s waiting for load results", test_name));
    end
  endtask

  always @(negedge clk) begin
    if (!rst && ld_dest != '0) begin
      assert (exp_tag_q.size() > 0)
        else stop_run($sformatf("load result for tag %0d arrived unexpectedly", ld_dest));
      assert (ld_dest == exp_tag_q[0])
        else stop_run($sformatf("CHECK FAILED %s: expected tag %0d, actual %0d",
                                exp_name_q[0], exp_tag_q[0], ld_dest));
      assert (ld_value == exp_val_q[0])
        else stop_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                exp_name_q[0], exp_val_q[0], ld_value));
      void'(exp_tag_q.pop_front());
      void'(exp_val_q.pop_front());
      void'(exp_name_q.pop_front());
    end
  end

  initial begin
    logic [`ROB_TAG_W-1:0] st;
    logic [`ROB_TAG_W-1:0] at;
    logic [`XLEN-1:0]      old;
    rst = 1'b1;
    {issue_dest, issue_qj, issue_qk, issue_vj, issue_vk, issue_imm} = '0;
    issue_op = lsb_pkg::op_lw;
    {alu_dest, alu_value, commit_dest, stall, tag} = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    test_name = "load_extend";
    mem.image[16] = 32'h80ff_7f01;
    mem.image[17] = 32'h7f80_00fe;
    for (int w = 16; w < 18; w++) begin
      for (int o = 0; o <= 4; o++) begin
        for (int b = 0; b < 4; b++) begin
          if (!((o == 2 && b != 0) || ((o == 1 || o == 4) && b % 2 == 1))) begin
            load_known(lsb_pkg::ls_op_e'(o), 32'(w * 4 + 8), 12'(b - 8));
          end
        end
      end
    end
    wait_done(200);

    test_name = "store_commit";
    old = mem.image[32];
    take_tag();
    st = tag;
    alloc_op(st, lsb_pkg::op_sh, '0, 32'h80, 32'h1234_beef, 12'd2);
    take_tag();
    expect_result(tag, {16'hbeef, old[15:0]});
    alloc_op(tag, lsb_pkg::op_lw, '0, 32'h80, '0, 12'd0);
    // nothing may reach memory while the store is uncommitted
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (!mem_valid) else stop_run("the store went to memory before its commit");
    end
    commit_dest = st;
    @(negedge clk);
    commit_dest = '0;
    wait_done(200);

    test_name = "late_base";
    take_tag();
    at = tag;
    take_tag();
    expect_result(tag, expect_load(lsb_pkg::op_lh, 32'h106, mem.image));
    alloc_op(tag, lsb_pkg::op_lh, at, 32'hdead_0000, '0, 12'd6);
    repeat (6) @(negedge clk);
    assert (!mem_valid) else stop_run("a load started before its base operand arrived");
    alu_dest  = at;
    alu_value = 32'h100;
    @(negedge clk);
    alu_dest = '0;
    wait_done(200);

    test_name = "same_cycle_bypass";
    take_tag();
    at = tag;
    take_tag();
    expect_result(tag, expect_load(lsb_pkg::op_lhu, 32'h11e, mem.image));
    alu_dest  = at;
    alu_value = 32'h120;
    alloc_op(tag, lsb_pkg::op_lhu, at, '0, '0, 12'hffe);
    alu_dest = '0;
    wait_done(200);

    test_name = "load_base";
    mem.image[24] = 32'h0000_0150;
    load_known(lsb_pkg::op_lw, 32'h60, 12'd0);
    st = tag;
    take_tag();
    expect_result(tag, expect_load(lsb_pkg::op_lbu, 32'h153, mem.image));
    alloc_op(tag, lsb_pkg::op_lbu, st, '0, '0, 12'd3);
    wait_done(200);

    test_name = "full_drain";
    stall = 1'b1;
    for (int i = 0; i < `LSB_DEPTH; i++) begin
      load_known(lsb_pkg::op_lw, {$random(seed)} & 32'h3fc, 12'd0);
    end
    assert (full) else stop_run("CHECK FAILED full_drain: expected full 1, actual 0");
    stall = 1'b0;
    wait_done(200);

    $display("all tests passed");
    $finish;
  end

endmodule

/* verilog/load_store_buffer.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module load_store_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`ROB_TAG_W-1:0] issue_dest,
  input  lsb_pkg::ls_op_e       issue_op,
  input  logic [`ROB_TAG_W-1:0] issue_qj,
  input  logic [`XLEN-1:0]      issue_vj,
  input  logic [`ROB_TAG_W-1:0] issue_qk,
  input  logic [`XLEN-1:0]      issue_vk,
  input  logic [`IMM_W-1:0]     issue_imm,
  input  logic [`ROB_TAG_W-1:0] alu_dest,
  input  logic [`XLEN-1:0]      alu_value,
  input  logic [`ROB_TAG_W-1:0] commit_dest,
  input  logic                  mem_ready,
  input  logic [`XLEN-1:0]      mem_rdata,
  output logic                  full,
  output logic                  mem_valid,
  output logic                  mem_we,
  output logic [`XLEN-1:0]      mem_addr,
  output logic [`XLEN-1:0]      mem_wdata,
  output logic [`STRB_W-1:0]    mem_strb,
  output logic [`ROB_TAG_W-1:0] ld_dest,
  output logic [`XLEN-1:0]      ld_value
);

  logic [`LSB_DEPTH-1:0] alloc_sel;
  lsb_pkg::ls_op_e       new_op;
  logic [`ROB_TAG_W-1:0] new_qj;
  logic [`XLEN-1:0]      new_vj;
  logic [`ROB_TAG_W-1:0] new_qk;
  logic [`XLEN-1:0]      new_vk;
  logic [`IMM_W-1:0]     new_imm;
  logic [`ROB_TAG_W-1:0] new_dest;
  logic [`LSB_DEPTH-1:0] release_sel;
  logic                  release_en;

  logic [`LSB_DEPTH-1:0] entry_busy;
  logic [`LSB_DEPTH-1:0] entry_ready;
  logic [`LSB_DEPTH-1:0] entry_is_store;
  logic [`LSB_DEPTH-1:0] entry_committed;
  lsb_pkg::ls_op_e       entry_op   [`LSB_DEPTH];
  logic [`XLEN-1:0]      entry_addr [`LSB_DEPTH];
  logic [`XLEN-1:0]      entry_data [`LSB_DEPTH];
  logic [`ROB_TAG_W-1:0] entry_dest [`LSB_DEPTH];

  lsb_alloc u_alloc (
    .clk(clk), .rst(rst),
    .issue_dest(issue_dest), .issue_op(issue_op),
    .issue_qj(issue_qj), .issue_vj(issue_vj),
    .issue_qk(issue_qk), .issue_vk(issue_vk), .issue_imm(issue_imm),
    .alu_dest(alu_dest), .alu_value(alu_value),
    .ld_dest(ld_dest), .ld_value(ld_value),
    .release_en(release_en), .alloc_sel(alloc_sel),
    .new_op(new_op), .new_qj(new_qj), .new_vj(new_vj),
    .new_qk(new_qk), .new_vk(new_vk), .new_imm(new_imm),
    .new_dest(new_dest), .full(full)
  );

  // one slot per queue position
  for (genvar i = 0; i < `LSB_DEPTH; i++) begin : g_entry
    lsb_entry u_entry (
      .clk(clk), .rst(rst), .alloc(alloc_sel[i]),
      .new_op(new_op), .new_qj(new_qj), .new_vj(new_vj),
      .new_qk(new_qk), .new_vk(new_vk), .new_imm(new_imm), .new_dest(new_dest),
      .alu_dest(alu_dest), .alu_value(alu_value),
      .ld_dest(ld_dest), .ld_value(ld_value),
      .commit_dest(commit_dest), .release_en(release_sel[i]),
      .busy(entry_busy[i]), .ready(entry_ready[i]),
      .is_store(entry_is_store[i]), .committed(entry_committed[i]),
      .op(entry_op[i]), .addr(entry_addr[i]),
      .data(entry_data[i]), .dest(entry_dest[i])
    );
  end

  lsb_mem_issue u_mem_issue (
    .clk(clk), .rst(rst),
    .entry_busy(entry_busy), .entry_ready(entry_ready),
    .entry_is_store(entry_is_store), .entry_committed(entry_committed),
    .entry_op(entry_op), .entry_addr(entry_addr),
    .entry_data(entry_data), .entry_dest(entry_dest),
    .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .release_sel(release_sel), .release_en(release_en),
    .mem_valid(mem_valid), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_strb(mem_strb),
    .ld_dest(ld_dest), .ld_value(ld_value)
  );

endmodule

/* verilog/lsb_alloc.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module lsb_alloc (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`ROB_TAG_W-1:0] issue_dest,
  input  lsb_pkg::ls_op_e       issue_op,
  input  logic [`ROB_TAG_W-1:0] issue_qj,
  input  logic [`XLEN-1:0]      issue_vj,
  input  logic [`ROB_TAG_W-1:0] issue_qk,
  input  logic [`XLEN-1:0]      issue_vk,
  input  logic [`IMM_W-1:0]     issue_imm,
  input  logic [`ROB_TAG_W-1:0] alu_dest,
  input  logic [`XLEN-1:0]      alu_value,
  input  logic [`ROB_TAG_W-1:0] ld_dest,
  input  logic [`XLEN-1:0]      ld_value,
  input  logic                  release_en,
  output logic [`LSB_DEPTH-1:0] alloc_sel,
  output lsb_pkg::ls_op_e       new_op,
  output logic [`ROB_TAG_W-1:0] new_qj,
  output logic [`XLEN-1:0]      new_vj,
  output logic [`ROB_TAG_W-1:0] new_qk,
  output logic [`XLEN-1:0]      new_vk,
  output logic [`IMM_W-1:0]     new_imm,
  output logic [`ROB_TAG_W-1:0] new_dest,
  output logic                  full
);

  localparam logic [`LSB_CNT_W-1:0] depth_cnt = `LSB_DEPTH;
  localparam logic [`LSB_DEPTH-1:0] sel_one = 1;

  logic [`LSB_PTR_W-1:0] tail;
  logic [`LSB_CNT_W-1:0] count;
  logic                  alloc;

  assign alloc     = issue_dest != '0;
  assign full      = count == depth_cnt;
  assign alloc_sel = alloc ? sel_one << tail : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (alloc && !release_en) begin
        count <= count + 1'b1;
      end else if (!alloc && release_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // same-cycle bypass, alu bus wins
  always_comb begin
    new_qj = issue_qj;
    new_vj = issue_vj;
    if (alu_dest != '0 && issue_qj == alu_dest) begin
      new_qj = '0;
      new_vj = alu_value;
    end else if (ld_dest != '0 && issue_qj == ld_dest) begin
      new_qj = '0;
      new_vj = ld_value;
    end
    new_qk = issue_qk;
    new_vk = issue_vk;
    if (alu_dest != '0 && issue_qk == alu_dest) begin
      new_qk = '0;
      new_vk = alu_value;
    end else if (ld_dest != '0 && issue_qk == ld_dest) begin
      new_qk = '0;
      new_vk = ld_value;
    end
  end

  assign new_op   = issue_op;
  assign new_imm  = issue_imm;
  assign new_dest = issue_dest;

endmodule

/* verilog/lsb_defines.svh */
`ifndef LSB_DEFINES_SVH
`define LSB_DEFINES_SVH

// queue geometry
`define LSB_DEPTH 8
`define LSB_PTR_W 3
`define LSB_CNT_W 4

// reorder buffer tag, zero means no tag
`define ROB_TAG_W 4

// datapath
`define XLEN 32
`define IMM_W 12

// memory port byte strobes
`define STRB_W 4

`endif

/* verilog/lsb_entry.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module lsb_entry (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  alloc,
  input  lsb_pkg::ls_op_e       new_op,
  input  logic [`ROB_TAG_W-1:0] new_qj,
  input  logic [`XLEN-1:0]      new_vj,
  input  logic [`ROB_TAG_W-1:0] new_qk,
  input  logic [`XLEN-1:0]      new_vk,
  input  logic [`IMM_W-1:0]     new_imm,
  input  logic [`ROB_TAG_W-1:0] new_dest,
  input  logic [`ROB_TAG_W-1:0] alu_dest,
  input  logic [`XLEN-1:0]      alu_value,
  input  logic [`ROB_TAG_W-1:0] ld_dest,
  input  logic [`XLEN-1:0]      ld_value,
  input  logic [`ROB_TAG_W-1:0] commit_dest,
  input  logic                  release_en,
  output logic                  busy,
  output logic                  ready,
  output logic                  is_store,
  output logic                  committed,
  output lsb_pkg::ls_op_e       op,
  output logic [`XLEN-1:0]      addr,
  output logic [`XLEN-1:0]      data,
  output logic [`ROB_TAG_W-1:0] dest
);

  logic [`ROB_TAG_W-1:0] qj;
  logic [`ROB_TAG_W-1:0] qk;
  logic [`XLEN-1:0]      vj;
  logic [`XLEN-1:0]      vk;
  logic [`IMM_W-1:0]     imm;
  logic [`XLEN-1:0]      offset;
  logic                  addr_done;
  logic                  do_add;

  assign offset = {{(`XLEN - `IMM_W){imm[`IMM_W-1]}}, imm};
  // base known and not yet added
  assign do_add = busy && !addr_done && qj == '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      addr_done <= 1'b0;
      committed <= 1'b0;
    end else if (alloc) begin
      busy      <= 1'b1;
      addr_done <= 1'b0;
      committed <= 1'b0;
    end else begin
      if (release_en) begin
        busy <= 1'b0;
      end
      if (do_add) begin
        addr_done <= 1'b1;
      end
      if (busy && is_store && commit_dest != '0 && commit_dest == dest) begin
        committed <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      op   <= new_op;
      qj   <= new_qj;
      vj   <= new_vj;
      qk   <= new_qk;
      vk   <= new_vk;
      imm  <= new_imm;
      dest <= new_dest;
    end else begin
      // vj turns into the effective address after the add
      if (do_add) begin
        vj <= vj + offset;
      end else if (qj != '0 && qj == alu_dest) begin
        qj <= '0;
        vj <= alu_value;
      end else if (qj != '0 && qj == ld_dest) begin
        qj <= '0;
        vj <= ld_value;
      end
      if (qk != '0 && qk == alu_dest) begin
        qk <= '0;
        vk <= alu_value;
      end else if (qk != '0 && qk == ld_dest) begin
        qk <= '0;
        vk <= ld_value;
      end
    end
  end

  assign is_store = op > lsb_pkg::op_lhu;
  // loads carry qk of zero from the issuer
  assign ready    = busy && addr_done && qk == '0;
  assign addr     = vj;
  assign data     = vk;

endmodule

/* verilog/lsb_mem_issue.sv */
`timescale 1ns/10ps
`include "lsb_defines.svh"

module lsb_mem_issue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`LSB_DEPTH-1:0] entry_busy,
  input  logic [`LSB_DEPTH-1:0] entry_ready,
  input  logic [`LSB_DEPTH-1:0] entry_is_store,
  input  logic [`LSB_DEPTH-1:0] entry_committed,
  input  lsb_pkg::ls_op_e       entry_op        [`LSB_DEPTH],
  input  logic [`XLEN-1:0]      entry_addr      [`LSB_DEPTH],
  input  logic [`XLEN-1:0]      entry_data      [`LSB_DEPTH],
  input  logic [`ROB_TAG_W-1:0] entry_dest      [`LSB_DEPTH],
  input  logic                  mem_ready,
  input  logic [`XLEN-1:0]      mem_rdata,
  output logic [`LSB_DEPTH-1:0] release_sel,
  output logic                  release_en,
  output logic                  mem_valid,
  output logic                  mem_we,
  output logic [`XLEN-1:0]      mem_addr,
  output logic [`XLEN-1:0]      mem_wdata,
  output logic [`STRB_W-1:0]    mem_strb,
  output logic [`ROB_TAG_W-1:0] ld_dest,
  output logic [`XLEN-1:0]      ld_value
);

  localparam logic st_idle = 1'b0;
  localparam logic st_wait = 1'b1;
  localparam logic [`LSB_DEPTH-1:0] sel_one = 1;

  logic                  state;
  logic [`LSB_PTR_W-1:0] head;
  lsb_pkg::ls_op_e       head_op;
  logic [`XLEN-1:0]      head_addr;
  logic [`XLEN-1:0]      head_data;
  logic [`ROB_TAG_W-1:0] head_dest;
  logic                  head_store;
  logic                  head_go;
  lsb_pkg::mem_word_u    wr_word;
  lsb_pkg::mem_word_u    rd_word;
  logic [`STRB_W-1:0]    wr_strb;
  logic [`XLEN-1:0]      ld_ext;

  assign head_op    = entry_op[head];
  assign head_addr  = entry_addr[head];
  assign head_data  = entry_data[head];
  assign head_dest  = entry_dest[head];
  assign head_store = entry_is_store[head];

  // stores also wait for the rob commit
  assign head_go = state == st_idle && entry_busy[head] && entry_ready[head] &&
                   (!head_store || entry_committed[head]);

  assign release_en  = state == st_wait && mem_ready;
  assign release_sel = release_en ? sel_one << head : '0;

  // store data into its lane
  always_comb begin
    wr_word = '0;
    wr_strb = '0;
    case (head_op)
      lsb_pkg::op_sb: begin
        wr_word.byte_lane[head_addr[1:0]] = head_data[7:0];
        wr_strb[head_addr[1:0]] = 1'b1;
      end
      lsb_pkg::op_sh: begin
        wr_word.half_lane[head_addr[1]] = head_data[15:0];
        wr_strb = head_addr[1] ? 4'b1100 : 4'b0011;
      end
      lsb_pkg::op_sw: begin
        wr_word = head_data;
        wr_strb = '1;
      end
      default: begin
      end
    endcase
  end

  // load lane pick and extension
  always_comb begin
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    rd_word  = mem_rdata;
    byte_val = rd_word.byte_lane[head_addr[1:0]];
    half_val = rd_word.half_lane[head_addr[1]];
    case (head_op)
      lsb_pkg::op_lb:  ld_ext = {{(`XLEN - 8){byte_val[7]}}, byte_val};
      lsb_pkg::op_lbu: ld_ext = {{(`XLEN - 8){1'b0}}, byte_val};
      lsb_pkg::op_lh:  ld_ext = {{(`XLEN - 16){half_val[15]}}, half_val};
      lsb_pkg::op_lhu: ld_ext = {{(`XLEN - 16){1'b0}}, half_val};
      default:         ld_ext = mem_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      head      <= '0;
      mem_valid <= 1'b0;
      mem_we    <= 1'b0;
      ld_dest   <= '0;
    end else begin
      ld_dest <= '0;
      case (state)
        st_idle: begin
          if (head_go) begin
            state     <= st_wait;
            mem_valid <= 1'b1;
            mem_we    <= head_store;
          end
        end
        st_wait: begin
          if (mem_ready) begin
            state     <= st_idle;
            mem_valid <= 1'b0;
            head      <= head + 1'b1;
            if (!head_store) begin
              ld_dest <= head_dest;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // access fields, held while waiting
  always_ff @(posedge clk) begin
    if (head_go) begin
      mem_addr  <= {head_addr[`XLEN-1:2], 2'b00};
      mem_wdata <= wr_word;
      mem_strb  <= wr_strb;
    end
    if (release_en) begin
      ld_value <= ld_ext;
    end
  end

endmodule

/* verilog/lsb_pkg.sv */
`include "lsb_defines.svh"

package lsb_pkg;

  // loads first, then stores
  typedef enum logic [3:0] {
    op_lb  = 4'd0,
    op_lh  = 4'd1,
    op_lw  = 4'd2,
    op_lbu = 4'd3,
    op_lhu = 4'd4,
    op_sb  = 4'd5,
    op_sh  = 4'd6,
    op_sw  = 4'd7
  } ls_op_e;

  // one memory word seen as byte lanes or half lanes
  typedef union packed {
    logic [`STRB_W-1:0][7:0]    byte_lane;
    logic [`STRB_W/2-1:0][15:0] half_lane;
  } mem_word_u;

endpackage

/* vlog.f */
+incdir+verilog
verilog/lsb_pkg.sv
verilog/lsb_alloc.sv
verilog/lsb_entry.sv
verilog/lsb_mem_issue.sv
verilog/load_store_buffer.sv
tb/lsb_tb_memory.sv
tb/lsb_properties.sv
tb/tb_load_store_buffer.sv
